// File: hw/rv32i_types.sv
`default_nettype none

package rv32i_types;

    localparam int ROB_DEPTH   = 32;
    localparam int RS_DEPTH    = 4;
    localparam int NUM_CLASSES = 4;
    localparam int ROB_IDX_W   = $clog2(ROB_DEPTH);
    localparam int RS_IDX_W    = $clog2(RS_DEPTH);

    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    typedef enum logic [1:0] {
        CLASS_ALU = 2'd0,
        CLASS_MUL = 2'd1,
        CLASS_BR  = 2'd2,
        CLASS_MEM = 2'd3
    } op_class_e;

    // waiting operand, producer tag in the low bits
    typedef struct packed {
        logic [31-ROB_IDX_W:0] zero;
        rob_idx_t              tag;
    } src_tag_t;

    // ready bit selects the reading
    typedef union packed {
        logic [31:0] value;
        src_tag_t    wait_tag;
    } src_operand_u;

    typedef struct packed {
        logic         ready;
        src_operand_u operand;
    } src_t;

    typedef struct packed {
        op_class_e   op_class;
        logic [3:0]  funct;
        logic [31:0] imm;
        rob_idx_t    rd_rob_idx;
        logic        src1_arch_ready;
        logic [31:0] src1_arch_data;
        rob_idx_t    src1_rob_idx;
        logic        src2_arch_ready;
        logic [31:0] src2_arch_data;
        rob_idx_t    src2_rob_idx;
    } dispatch_t;

    typedef struct packed {
        op_class_e   op_class;
        logic [3:0]  funct;
        logic [31:0] imm;
        rob_idx_t    rd_rob_idx;
        src_t        src1;
        src_t        src2;
    } rs_entry_t;

    typedef struct packed {
        logic        valid;
        rob_idx_t    rob_idx;
        logic [31:0] data;
    } cdb_t;

endpackage

`default_nettype wire

// File: hw/operand_capture.sv
`timescale 1ns/1ps
`default_nettype none

module operand_capture (
    input  rv32i_types::dispatch_t dispatch,
    input  logic                   src1_done,
    input  logic                   src2_done,
    input  logic [31:0]            src1_value,
    input  logic [31:0]            src2_value,
    input  rv32i_types::cdb_t      cdb,
    output rv32i_types::rs_entry_t entry
);

    // priority is arch value, then completed result, then same-cycle cdb
    function automatic rv32i_types::src_t resolve(
        input logic                  arch_ready,
        input logic [31:0]           arch_data,
        input rv32i_types::rob_idx_t idx,
        input logic                  done,
        input logic [31:0]           value,
        input rv32i_types::cdb_t     bus
    );
        rv32i_types::src_t s;
        s.ready = 1'b1;
        if (arch_ready) begin
            s.operand.value = arch_data;
        end else if (done) begin
            s.operand.value = value;
        end else if (bus.valid && (bus.rob_idx == idx)) begin
            s.operand.value = bus.data;
        end else begin
            // still pending, keep producer tag
            s.ready = 1'b0;
            s.operand.wait_tag.zero = '0;
            s.operand.wait_tag.tag = idx;
        end
        return s;
    endfunction

    always_comb begin
        entry.op_class   = dispatch.op_class;
        entry.funct      = dispatch.funct;
        entry.imm        = dispatch.imm;
        entry.rd_rob_idx = dispatch.rd_rob_idx;
        entry.src1 = resolve(dispatch.src1_arch_ready, dispatch.src1_arch_data,
                             dispatch.src1_rob_idx, src1_done, src1_value, cdb);
        entry.src2 = resolve(dispatch.src2_arch_ready, dispatch.src2_arch_data,
                             dispatch.src2_rob_idx, src2_done, src2_value, cdb);
    end

endmodule

`default_nettype wire

// File: hw/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   write,
    input  rv32i_types::rs_entry_t new_entry,
    input  rv32i_types::cdb_t      cdb,
    input  logic                   issue_ready,
    output logic                   has_space,
    output logic                   issue_valid,
    output rv32i_types::rs_entry_t issue_entry
);

    rv32i_types::rs_entry_t slots [rv32i_types::RS_DEPTH];
    logic [rv32i_types::RS_DEPTH-1:0] busy;

    logic [rv32i_types::RS_IDX_W-1:0] free_sel;
    logic [rv32i_types::RS_IDX_W-1:0] ready_sel;
    logic [rv32i_types::RS_IDX_W-1:0] issue_sel;
    logic [rv32i_types::RS_IDX_W-1:0] held_slot;
    logic                             any_ready;
    logic                             held;
    logic                             do_write;
    logic                             do_issue;

    // tag match on the broadcast turns a waiting source into a value
    function automatic rv32i_types::src_t wake(
        input rv32i_types::src_t s,
        input rv32i_types::cdb_t bus
    );
        rv32i_types::src_t r;
        r = s;
        if (!s.ready && bus.valid && (s.operand.wait_tag.tag == bus.rob_idx)) begin
            r.ready = 1'b1;
            r.operand.value = bus.data;
        end
        return r;
    endfunction

    // lowest free slot and lowest ready slot
    always_comb begin
        free_sel  = '0;
        ready_sel = '0;
        any_ready = 1'b0;
        for (int i = rv32i_types::RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_sel = rv32i_types::RS_IDX_W'(i);
            end
            if (busy[i] && slots[i].src1.ready && slots[i].src2.ready) begin
                ready_sel = rv32i_types::RS_IDX_W'(i);
                any_ready = 1'b1;
            end
        end
    end

    // a stalled offer keeps its slot until taken
    assign issue_sel   = held ? held_slot : ready_sel;
    assign issue_valid = held | any_ready;
    assign issue_entry = slots[issue_sel];
    assign has_space   = ~&busy;
    assign do_write    = write & has_space;
    assign do_issue    = issue_valid & issue_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= '0;
            held      <= 1'b0;
            held_slot <= '0;
        end else begin
            if (do_issue) begin
                busy[issue_sel] <= 1'b0;
            end
            if (do_write) begin
                busy[free_sel] <= 1'b1;
            end
            held      <= issue_valid & ~issue_ready;
            held_slot <= issue_sel;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rv32i_types::RS_DEPTH; i++) begin
            if (do_write && (free_sel == rv32i_types::RS_IDX_W'(i))) begin
                slots[i] <= new_entry;
            end else begin
                slots[i].src1 <= wake(slots[i].src1, cdb);
                slots[i].src2 <= wake(slots[i].src2, cdb);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rob_value_table.sv
`timescale 1ns/1ps
`default_nettype none

module rob_value_table (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv32i_types::cdb_t     cdb,
    input  logic                  clear,
    input  rv32i_types::rob_idx_t clear_idx,
    input  rv32i_types::rob_idx_t rd1_idx,
    input  rv32i_types::rob_idx_t rd2_idx,
    output logic                  rd1_done,
    output logic                  rd2_done,
    output logic [31:0]           rd1_value,
    output logic [31:0]           rd2_value
);

    logic [rv32i_types::ROB_DEPTH-1:0] done;
    logic [31:0]                       value [rv32i_types::ROB_DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= '0;
        end else begin
            if (cdb.valid) begin
                done[cdb.rob_idx] <= 1'b1;
            end
            // reallocation beats a same-cycle broadcast
            if (clear) begin
                done[clear_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cdb.valid) begin
            value[cdb.rob_idx] <= cdb.data;
        end
    end

    assign rd1_done  = done[rd1_idx];
    assign rd2_done  = done[rd2_idx];
    assign rd1_value = value[rd1_idx];
    assign rd2_value = value[rd2_idx];

endmodule

`default_nettype wire

// File: hw/dispatch_issue.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_issue (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  rv32i_types::dispatch_t               dispatch,
    input  logic                                 dispatch_valid,
    input  rv32i_types::cdb_t                    cdb,
    input  logic                                 src1_done,
    input  logic                                 src2_done,
    input  logic [31:0]                          src1_value,
    input  logic [31:0]                          src2_value,
    input  logic [rv32i_types::NUM_CLASSES-1:0]  issue_ready,
    output logic                                 dispatch_ready,
    output rv32i_types::rob_idx_t                src1_idx,
    output rv32i_types::rob_idx_t                src2_idx,
    output logic                                 alloc,
    output logic [rv32i_types::NUM_CLASSES-1:0]  issue_valid,
    output rv32i_types::rs_entry_t               issue_alu,
    output rv32i_types::rs_entry_t               issue_mul,
    output rv32i_types::rs_entry_t               issue_br,
    output rv32i_types::rs_entry_t               issue_mem
);

    rv32i_types::rs_entry_t                new_entry;
    logic [rv32i_types::NUM_CLASSES-1:0]   has_space;
    logic [rv32i_types::NUM_CLASSES-1:0]   write;

    assign src1_idx = dispatch.src1_rob_idx;
    assign src2_idx = dispatch.src2_rob_idx;

    operand_capture capture (
        .dispatch   (dispatch),
        .src1_done  (src1_done),
        .src2_done  (src2_done),
        .src1_value (src1_value),
        .src2_value (src2_value),
        .cdb        (cdb),
        .entry      (new_entry)
    );

    // only the target class station gates the handshake
    assign dispatch_ready = has_space[dispatch.op_class];
    assign alloc          = dispatch_valid & dispatch_ready;

    always_comb begin
        write = '0;
        write[dispatch.op_class] = alloc;
    end

    reservation_station alu_rs (
        .clk(clk), .arst_n(arst_n), .write(write[rv32i_types::CLASS_ALU]),
        .new_entry(new_entry), .cdb(cdb), .issue_ready(issue_ready[rv32i_types::CLASS_ALU]),
        .has_space(has_space[rv32i_types::CLASS_ALU]),
        .issue_valid(issue_valid[rv32i_types::CLASS_ALU]), .issue_entry(issue_alu)
    );

    reservation_station mul_rs (
        .clk(clk), .arst_n(arst_n), .write(write[rv32i_types::CLASS_MUL]),
        .new_entry(new_entry), .cdb(cdb), .issue_ready(issue_ready[rv32i_types::CLASS_MUL]),
        .has_space(has_space[rv32i_types::CLASS_MUL]),
        .issue_valid(issue_valid[rv32i_types::CLASS_MUL]), .issue_entry(issue_mul)
    );

    reservation_station br_rs (
        .clk(clk), .arst_n(arst_n), .write(write[rv32i_types::CLASS_BR]),
        .new_entry(new_entry), .cdb(cdb), .issue_ready(issue_ready[rv32i_types::CLASS_BR]),
        .has_space(has_space[rv32i_types::CLASS_BR]),
        .issue_valid(issue_valid[rv32i_types::CLASS_BR]), .issue_entry(issue_br)
    );

    reservation_station mem_rs (
        .clk(clk), .arst_n(arst_n), .write(write[rv32i_types::CLASS_MEM]),
        .new_entry(new_entry), .cdb(cdb), .issue_ready(issue_ready[rv32i_types::CLASS_MEM]),
        .has_space(has_space[rv32i_types::CLASS_MEM]),
        .issue_valid(issue_valid[rv32i_types::CLASS_MEM]), .issue_entry(issue_mem)
    );

endmodule

`default_nettype wire

// File: hw/issue_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module issue_subsystem (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  rv32i_types::dispatch_t               dispatch,
    input  logic                                 dispatch_valid,
    input  rv32i_types::cdb_t                    cdb,
    input  logic [rv32i_types::NUM_CLASSES-1:0]  issue_ready,
    output logic                                 dispatch_ready,
    output logic [rv32i_types::NUM_CLASSES-1:0]  issue_valid,
    output rv32i_types::rs_entry_t               issue_alu,
    output rv32i_types::rs_entry_t               issue_mul,
    output rv32i_types::rs_entry_t               issue_br,
    output rv32i_types::rs_entry_t               issue_mem
);

    rv32i_types::rob_idx_t src1_idx;
    rv32i_types::rob_idx_t src2_idx;
    logic                  src1_done;
    logic                  src2_done;
    logic [31:0]           src1_value;
    logic [31:0]           src2_value;
    logic                  alloc;

    rob_value_table value_table (
        .clk       (clk),
        .arst_n    (arst_n),
        .cdb       (cdb),
        .clear     (alloc),
        .clear_idx (dispatch.rd_rob_idx),
        .rd1_idx   (src1_idx),
        .rd2_idx   (src2_idx),
        .rd1_done  (src1_done),
        .rd2_done  (src2_done),
        .rd1_value (src1_value),
        .rd2_value (src2_value)
    );

    dispatch_issue dispatch_stage (
        .clk(clk), .arst_n(arst_n), .dispatch(dispatch), .dispatch_valid(dispatch_valid),
        .cdb(cdb), .src1_done(src1_done), .src2_done(src2_done),
        .src1_value(src1_value), .src2_value(src2_value), .issue_ready(issue_ready),
        .dispatch_ready(dispatch_ready), .src1_idx(src1_idx), .src2_idx(src2_idx),
        .alloc(alloc), .issue_valid(issue_valid), .issue_alu(issue_alu),
        .issue_mul(issue_mul), .issue_br(issue_br), .issue_mem(issue_mem)
    );

endmodule

`default_nettype wire

// File: test/tb_issue_model.svh
`ifndef TB_ISSUE_MODEL_SVH
`define TB_ISSUE_MODEL_SVH

// capture priority, a pending source gets the value broadcast for it later
function automatic rv32i_types::src_t expect_src(input logic arch_ready,
        input logic [31:0] arch_data, input rv32i_types::rob_idx_t idx,
        input rv32i_types::cdb_t c);
    rv32i_types::src_t s;
    s.ready = 1'b1;
    if (arch_ready) begin
        s.operand.value = arch_data;
    end else if (model_done[idx]) begin
        s.operand.value = model_value[idx];
    end else if (c.valid && (c.rob_idx == idx)) begin
        s.operand.value = c.data;
    end else begin
        s.operand.value = bcast_value[idx];
    end
    return s;
endfunction

function automatic rv32i_types::rs_entry_t expect_entry(input rv32i_types::dispatch_t d,
        input rv32i_types::cdb_t c);
    rv32i_types::rs_entry_t e;
    e.op_class   = d.op_class;
    e.funct      = d.funct;
    e.imm        = d.imm;
    e.rd_rob_idx = d.rd_rob_idx;
    e.src1       = expect_src(d.src1_arch_ready, d.src1_arch_data, d.src1_rob_idx, c);
    e.src2       = expect_src(d.src2_arch_ready, d.src2_arch_data, d.src2_rob_idx, c);
    return e;
endfunction

task automatic check_entry(input string name, input rv32i_types::rs_entry_t got,
        input rv32i_types::rs_entry_t want);
    if (got !== want) begin
        $display("Error at %0t: %s got %h expected %h", $time, name, got, want);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
        $display("Error at %0t: %s got %b expected %b", $time, name, got, want);
        errors++;
    end
endtask

`endif

// File: test/tb_issue_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_subsystem;

    logic                                clk = 1'b0;
    logic                                arst_n;
    rv32i_types::dispatch_t              dispatch;
    logic                                dispatch_valid;
    rv32i_types::cdb_t                   cdb;
    logic [rv32i_types::NUM_CLASSES-1:0] issue_ready;
    logic                                dispatch_ready;
    logic [rv32i_types::NUM_CLASSES-1:0] issue_valid;
    rv32i_types::rs_entry_t              issue_alu;
    rv32i_types::rs_entry_t              issue_mul;
    rv32i_types::rs_entry_t              issue_br;
    rv32i_types::rs_entry_t              issue_mem;

    // shadow of the value table plus values still owed on the cdb
    logic [rv32i_types::ROB_DEPTH-1:0] model_done = '0;
    logic [31:0]                       model_value [rv32i_types::ROB_DEPTH];
    logic [31:0]                       bcast_value [rv32i_types::ROB_DEPTH];
    logic [rv32i_types::ROB_DEPTH-1:0] owed = '0;
    rv32i_types::rs_entry_t            exp_q [rv32i_types::NUM_CLASSES][$];
    rv32i_types::rs_entry_t            exp_next;
    rv32i_types::rob_idx_t             next_rd = 5'd16;
    logic                              random_mode = 1'b0;
    int                                seed = 32'hf62a;
    int                                errors = 0;
    int                                tests = 0;
    int                                err_mark = 0;

    issue_subsystem DUT (.*);

    `include "tb_issue_model.svh"

    always #50 clk = ~clk;

    function automatic rv32i_types::rs_entry_t issue_payload(input int c);
        case (c)
            0: return issue_alu;
            1: return issue_mul;
            2: return issue_br;
            default: return issue_mem;
        endcase
    endfunction

    function automatic rv32i_types::dispatch_t make_op(input rv32i_types::op_class_e cls,
            input logic r1, input logic [31:0] v1, input rv32i_types::rob_idx_t t1,
            input logic r2, input logic [31:0] v2, input rv32i_types::rob_idx_t t2);
        rv32i_types::dispatch_t d;
        d.op_class        = cls;
        d.funct           = 4'($random(seed));
        d.imm             = $random(seed);
        d.rd_rob_idx      = next_rd;
        d.src1_arch_ready = r1;
        d.src1_arch_data  = v1;
        d.src1_rob_idx    = t1;
        d.src2_arch_ready = r2;
        d.src2_arch_data  = v2;
        d.src2_rob_idx    = t2;
        next_rd++;
        return d;
    endfunction

    function automatic rv32i_types::dispatch_t ready_op(input rv32i_types::op_class_e cls);
        return make_op(cls, 1'b1, $random(seed), 5'd0, 1'b1, $random(seed), 5'd0);
    endfunction

    // a waiting source with no producer in flight gets one
    function automatic void owe(input logic arch_ready, input rv32i_types::rob_idx_t t);
        if (!arch_ready && !model_done[t] && !owed[t]) begin
            owed[t] = 1'b1;
            bcast_value[t] = $random(seed);
        end
    endfunction

    function automatic rv32i_types::cdb_t next_cdb();
        rv32i_types::cdb_t     c;
        rv32i_types::rob_idx_t k;
        int                    r;
        c = '0;
        r = $random(seed);
        for (int i = 0; i < rv32i_types::ROB_DEPTH; i++) begin
            k = r[12:8] + i[4:0];
            if (random_mode && r[0] && !c.valid && owed[k]) begin
                owed[k] = 1'b0;
                c = {1'b1, k, bcast_value[k]};
            end
        end
        return c;
    endfunction

    // called just after a falling edge
    task automatic drive(input rv32i_types::dispatch_t d, input logic v,
            input rv32i_types::cdb_t c);
        dispatch       = d;
        dispatch_valid = v;
        cdb            = c;
        if (random_mode) begin
            issue_ready = 4'($random(seed));
        end
        exp_next = expect_entry(d, c);
    endtask

    task automatic send(input rv32i_types::dispatch_t d, input rv32i_types::cdb_t c);
        int n;
        @(negedge clk);
        drive(d, 1'b1, c);
        for (n = 0; n < 200; n++) begin
            @(posedge clk);
            if (dispatch_ready) begin
                break;
            end
            @(negedge clk);
            drive(d, 1'b1, next_cdb());
        end
        if (n == 200) begin
            $display("timeout: dispatch of rob index %0d was never accepted", d.rd_rob_idx);
            errors++;
        end
        @(negedge clk);
        drive(d, 1'b0, next_cdb());
    endtask

    task automatic bcast(input rv32i_types::rob_idx_t idx, input logic [31:0] val);
        @(negedge clk);
        drive(dispatch, 1'b0, {1'b1, idx, val});
        @(negedge clk);
        drive(dispatch, 1'b0, next_cdb());
    endtask

    task automatic drain();
        int n;
        int left;
        for (n = 0; n < 200; n++) begin
            @(negedge clk);
            left = 0;
            for (int c = 0; c < rv32i_types::NUM_CLASSES; c++) begin
                left += exp_q[c].size();
            end
            if (left == 0) begin
                break;
            end
        end
        if (n == 200) begin
            $display("timeout: expected issues still outstanding after 200 cycles");
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    // shadow table update and issue compare
    always @(posedge clk) begin
        rv32i_types::rs_entry_t got;
        int                     hit;
        if (arst_n) begin
            if (cdb.valid) begin
                model_done[cdb.rob_idx]  = 1'b1;
                model_value[cdb.rob_idx] = cdb.data;
            end
            if (dispatch_valid && dispatch_ready) begin
                exp_q[dispatch.op_class].push_back(exp_next);
                model_done[dispatch.rd_rob_idx] = 1'b0;
            end
            for (int c = 0; c < rv32i_types::NUM_CLASSES; c++) begin
                if (issue_valid[c] && issue_ready[c]) begin
                    got = issue_payload(c);
                    hit = -1;
                    for (int i = 0; i < exp_q[c].size(); i++) begin
                        if (exp_q[c][i].rd_rob_idx == got.rd_rob_idx) begin
                            hit = i;
                        end
                    end
                    if (hit < 0) begin
                        $display("class %0d issued rob index %0d that was not expected", c,
                                 got.rd_rob_idx);
                        errors++;
                    end else begin
                        check_entry($sformatf("issue entry class %0d", c), got, exp_q[c][hit]);
                        exp_q[c].delete(hit);
                    end
                end
            end
        end
    end

    initial begin
        rv32i_types::dispatch_t d;
        rv32i_types::dispatch_t d5;
        int                     r;
        arst_n         = 1'b0;
        dispatch       = '0;
        dispatch_valid = 1'b0;
        cdb            = '0;
        issue_ready    = '1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        @(posedge clk);
        for (int c = 0; c < rv32i_types::NUM_CLASSES; c++) begin
            check_bit("issue_valid", issue_valid[c], 1'b0);
        end
        check_bit("dispatch_ready", dispatch_ready, 1'b1);
        end_test("reset state");

        for (int c = 0; c < rv32i_types::NUM_CLASSES; c++) begin
            send(ready_op(rv32i_types::op_class_e'(c[1:0])), '0);
            @(posedge clk);
            check_bit("issue_valid", issue_valid[c], 1'b1);
        end
        drain();
        end_test("ready operands per class");

        // src1 from the table, src2 from the same-cycle bypass
        bcast(5'd5, 32'h1234_5678);
        d = make_op(rv32i_types::CLASS_ALU, 1'b0, 32'd0, 5'd5, 1'b0, 32'd0, 5'd6);
        send(d, {1'b1, 5'd6, 32'hcafe_f00d});
        drain();
        end_test("table and bypass");

        bcast_value[10] = 32'h0a0a_0001;
        bcast_value[11] = 32'h0b0b_0002;
        send(make_op(rv32i_types::CLASS_MUL, 1'b0, 32'd0, 5'd10, 1'b1, 32'd7, 5'd0), '0);
        send(make_op(rv32i_types::CLASS_MUL, 1'b1, 32'd9, 5'd0, 1'b0, 32'd0, 5'd11), '0);
        repeat (3) @(posedge clk);
        check_bit("issue_valid", issue_valid[rv32i_types::CLASS_MUL], 1'b0);
        bcast(5'd11, bcast_value[11]);
        bcast(5'd10, bcast_value[10]);
        drain();
        end_test("wakeup on broadcast");

        @(negedge clk);
        issue_ready = 4'b1110;
        repeat (4) send(ready_op(rv32i_types::CLASS_ALU), '0);
        d5 = ready_op(rv32i_types::CLASS_ALU);
        @(negedge clk);
        drive(d5, 1'b0, '0);
        @(posedge clk);
        check_bit("dispatch_ready", dispatch_ready, 1'b0);
        send(ready_op(rv32i_types::CLASS_MUL), '0);
        @(negedge clk);
        issue_ready = '1;
        send(d5, '0);
        drain();
        end_test("back-pressure");

        random_mode = 1'b1;
        repeat (200) begin
            r = $random(seed);
            d = make_op(rv32i_types::op_class_e'(r[1:0]), r[2], $random(seed), r[12:8],
                        r[3], $random(seed), r[20:16]);
            owe(d.src1_arch_ready, d.src1_rob_idx);
            owe(d.src2_arch_ready, d.src2_rob_idx);
            send(d, next_cdb());
        end
        // producers still owed
        for (int i = 0; i < rv32i_types::ROB_DEPTH; i++) begin
            if (owed[i]) begin
                owed[i] = 1'b0;
                bcast(rv32i_types::rob_idx_t'(i), bcast_value[i]);
            end
        end
        random_mode = 1'b0;
        @(negedge clk);
        issue_ready = '1;
        drain();
        end_test("random mix");

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+test
hw/rv32i_types.sv
hw/operand_capture.sv
hw/reservation_station.sv
hw/rob_value_table.sv
hw/dispatch_issue.sv
hw/issue_subsystem.sv
test/tb_issue_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the issue stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_issue_subsystem -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_issue_subsystem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
